// File: hw/hps_audio_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the host port, audio mixer and board I/O
//   Sample, host word and command byte widths
//   Host command codes
//   Stereo sample, mixer setting and LED structs
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package hps_audio_pkg;

	// Widths
	localparam int SAMPLE_W = 16;
	localparam int IO_W     = 16;
	localparam int CMD_W    = 8;

	// Host commands
	localparam logic [CMD_W-1:0] CMD_LED = 8'h25;
	localparam logic [CMD_W-1:0] CMD_VOL = 8'h26;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Left in the high half
	typedef struct packed {
		sample_t l;
		sample_t r;
	} stereo_t;

	// att[4] mutes, att[3:0] is the right shift
	typedef struct packed {
		logic [4:0] att;
		logic [1:0] mix;
		logic       is_signed;
	} mix_cfg_t;

	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} led_cfg_t;

	// LED requests from the core
	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
	} led_status_t;

endpackage

`default_nettype wire

// File: hw/hps_cmd_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Host command port
//   Strobe detection on the level clock and acknowledge echo
//   Command byte and data word decoding
//   LED override and volume attenuation setting registers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module hps_cmd_decoder (
	input  logic                           clk,
	input  logic                           resetd,
	input  logic                           i_io_clk,
	input  logic                           i_io_sel,
	input  logic [hps_audio_pkg::IO_W-1:0] i_io_din,
	output logic                           o_io_ack,
	output hps_audio_pkg::led_cfg_t        o_led_cfg,
	output logic [4:0]                     o_att
);

	import hps_audio_pkg::*;

	logic             seen;
	logic             strobe;
	logic             stb_q;
	logic [IO_W-1:0]  din_q;
	logic             has_cmd;
	logic [CMD_W-1:0] cmd;
	led_cfg_t         led_q;
	logic [4:0]       att_q;

	////////////////////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////////////////////

	// High for the first cycle of a raised io clock
	assign strobe = i_io_clk & ~seen;

	always_ff @(posedge clk) begin
		if (resetd) begin
			seen     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			seen     <= i_io_clk;
			o_io_ack <= seen;
		end
	end

	// Word capture, decoded one cycle later in step with the ack
	always_ff @(posedge clk) begin
		if (resetd) begin
			stb_q <= 1'b0;
		end else begin
			stb_q <= strobe & i_io_sel;
		end
	end

	always_ff @(posedge clk) begin
		if (strobe) begin
			din_q <= i_io_din;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command decoding
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd     <= '0;
			led_q   <= '0;
			att_q   <= '0;
		end else if (!i_io_sel) begin
			// Deselect closes the command
			has_cmd <= 1'b0;
			cmd     <= '0;
		end else if (stb_q) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= din_q[CMD_W-1:0];
			end else begin
				case (cmd)
					CMD_LED: led_q <= led_cfg_t'(din_q);
					CMD_VOL: att_q <= din_q[4:0];
					default: ;
				endcase
			end
		end
	end

	assign o_led_cfg = led_q;
	assign o_att     = att_q;

	// Settings move only two cycles after a selected strobe of an open command
	assert property (@(posedge clk) disable iff (resetd)
		!$stable({led_q, att_q}) |-> ($past(strobe && i_io_sel, 2) && $past(has_cmd)));

endmodule

`default_nettype wire

// File: hw/audio_mix_channel.sv
////////////////////////////////////////////////////////////////////////////
// One audio mixer channel
//   Glitch filter on the core sample
//   Host sum, crossfeed with the partner channel
//   Attenuation or mute, saturation to 16 bits
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module audio_mix_channel (
	input  logic                      clk,
	input  logic                      resetd,
	input  hps_audio_pkg::sample_t    i_core,
	input  hps_audio_pkg::sample_t    i_host,
	input  hps_audio_pkg::mix_cfg_t   i_cfg,
	input  hps_audio_pkg::sample_t    i_pre,
	output hps_audio_pkg::sample_t    o_pre,
	output hps_audio_pkg::sample_t    o_out
);

	import hps_audio_pkg::*;

	// One guard bit for the sum
	localparam int AW = SAMPLE_W + 1;

	sample_t              d1;
	sample_t              d2;
	sample_t              ca;
	logic signed [AW-1:0] a1;
	logic signed [AW-1:0] a2;
	logic signed [AW-1:0] a3;
	logic signed [AW-1:0] a4;

	////////////////////////////////////////////////////////////////////////////
	// Glitch filter
	////////////////////////////////////////////////////////////////////////////

	// Sample passes once it matched over two cycles
	always_ff @(posedge clk) begin
		if (resetd) begin
			d1 <= '0;
			d2 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			if (d1 == d2) begin
				ca <= d1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Mix pipeline
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			o_pre <= '0;
			a3    <= '0;
			a4    <= '0;
			o_out <= '0;
		end else begin
			// Unsigned cores are halved around zero
			if (i_cfg.is_signed) begin
				a1 <= AW'(ca);
			end else begin
				a1 <= $signed({2'b00, ca[SAMPLE_W-1:1]});
			end

			// Host audio is always signed
			a2 <= a1 + AW'(i_host);

			o_pre <= a2[AW-1:1];

			// Crossfeed
			case (i_cfg.mix)
				2'd0: a3 <= a2;
				2'd1: a3 <= a2 - (a2 >>> 3) + (i_pre >>> 2);
				2'd2: a3 <= a2 - (a2 >>> 2) + (i_pre >>> 1);
				2'd3: a3 <= (a2 >>> 1) + AW'(i_pre);
			endcase

			if (i_cfg.att[4]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_cfg.att[3:0];
			end

			// Clamp when the top two bits differ
			if (a4[AW-1] ^ a4[AW-2]) begin
				o_out <= {a4[AW-1], {(SAMPLE_W-1){a4[AW-2]}}};
			end else begin
				o_out <= a4[SAMPLE_W-1:0];
			end
		end
	end

	// Partner and config inputs must keep the output defined
	assert property (@(posedge clk) disable iff (resetd) !$isunknown(o_out));

endmodule

`default_nettype wire

// File: hw/board_io.sv
////////////////////////////////////////////////////////////////////////////
// Main-board I/O
//   Shared debounce tick and 8-sample button debouncers
//   LED composition from host override and core requests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module board_io #(
	parameter int DEBOUNCE_TICK = 100000
) (
	input  logic                        clk,
	input  logic                        resetd,
	input  logic                        i_btn_user,
	input  logic                        i_btn_osd,
	input  hps_audio_pkg::led_cfg_t     i_led_cfg,
	input  hps_audio_pkg::led_status_t  i_led_status,
	output logic                        o_btn_user,
	output logic                        o_btn_osd,
	output logic [7:0]                  o_led
);

	localparam int CNT_W = $clog2(DEBOUNCE_TICK + 1);

	logic [CNT_W-1:0] tick_cnt;
	logic             tick;
	logic [1:0]       btn_raw;
	logic [1:0][7:0]  hist;
	logic [1:0]       btn_q;
	logic             led_p;
	logic [7:0]       led_pattern;

	////////////////////////////////////////////////////////////////////////////
	// Debounce
	////////////////////////////////////////////////////////////////////////////

	assign tick = (tick_cnt == CNT_W'(DEBOUNCE_TICK - 1));

	always_ff @(posedge clk) begin
		if (resetd || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// Index 0 is user, 1 is OSD
	assign btn_raw = {i_btn_osd, i_btn_user};

	always_ff @(posedge clk) begin
		if (resetd) begin
			hist  <= '0;
			btn_q <= '0;
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				hist[i] <= {hist[i][6:0], btn_raw[i]};
				if (&hist[i]) begin
					btn_q[i] <= 1'b1;
				end else if (hist[i] == '0) begin
					btn_q[i] <= 1'b0;
				end
			end
		end
	end

	assign o_btn_user = btn_q[0];
	assign o_btn_osd  = btn_q[1];

	////////////////////////////////////////////////////////////////////////////
	// LEDs
	////////////////////////////////////////////////////////////////////////////

	// Power LED is on unless the core takes control of it
	assign led_p = i_led_status.power[1] ? i_led_status.power[0] : 1'b1;

	assign led_pattern = {3'b000, i_led_status.disk[0], 1'b0, led_p, 1'b0, i_led_status.user};

	assign o_led = (i_led_cfg.overtake & i_led_cfg.state) |
		(~i_led_cfg.overtake & led_pattern);

	assert property (@(posedge clk) disable iff (resetd) tick_cnt <= DEBOUNCE_TICK);

endmodule

`default_nettype wire

// File: hw/hps_audio_top.sv
////////////////////////////////////////////////////////////////////////////
// Board shell top level
//   Host command decoder, cross-coupled stereo mixer channels
//   Main-board buttons and LEDs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module hps_audio_top #(
	parameter int DEBOUNCE_TICK = 100000
) (
	input  logic                           clk,
	input  logic                           resetd,
	input  logic                           i_io_clk,
	input  logic                           i_io_sel,
	input  logic [hps_audio_pkg::IO_W-1:0] i_io_din,
	input  hps_audio_pkg::stereo_t         i_core_audio,
	input  hps_audio_pkg::stereo_t         i_host_audio,
	input  logic [1:0]                     i_mix,
	input  logic                           i_is_signed,
	input  logic                           i_btn_user,
	input  logic                           i_btn_osd,
	input  hps_audio_pkg::led_status_t     i_led_status,
	output logic                           o_io_ack,
	output hps_audio_pkg::stereo_t         o_audio,
	output logic [7:0]                     o_led,
	output logic                           o_btn_user,
	output logic                           o_btn_osd
);

	import hps_audio_pkg::*;

	led_cfg_t   led_cfg;
	logic [4:0] att;
	mix_cfg_t   mix_cfg;
	sample_t    pre_l;
	sample_t    pre_r;
	sample_t    out_l;
	sample_t    out_r;

	assign mix_cfg = '{att: att, mix: i_mix, is_signed: i_is_signed};
	assign o_audio = '{l: out_l, r: out_r};

	hps_cmd_decoder u_decoder (
		.clk       (clk),
		.resetd    (resetd),
		.i_io_clk  (i_io_clk),
		.i_io_sel  (i_io_sel),
		.i_io_din  (i_io_din),
		.o_io_ack  (o_io_ack),
		.o_led_cfg (led_cfg),
		.o_att     (att)
	);

	// Each channel mixes in the other's pre value
	audio_mix_channel u_mix_l (
		.clk    (clk),
		.resetd (resetd),
		.i_core (i_core_audio.l),
		.i_host (i_host_audio.l),
		.i_cfg  (mix_cfg),
		.i_pre  (pre_r),
		.o_pre  (pre_l),
		.o_out  (out_l)
	);

	audio_mix_channel u_mix_r (
		.clk    (clk),
		.resetd (resetd),
		.i_core (i_core_audio.r),
		.i_host (i_host_audio.r),
		.i_cfg  (mix_cfg),
		.i_pre  (pre_l),
		.o_pre  (pre_r),
		.o_out  (out_r)
	);

	board_io #(
		.DEBOUNCE_TICK (DEBOUNCE_TICK)
	) u_board_io (
		.clk          (clk),
		.resetd       (resetd),
		.i_btn_user   (i_btn_user),
		.i_btn_osd    (i_btn_osd),
		.i_led_cfg    (led_cfg),
		.i_led_status (i_led_status),
		.o_btn_user   (o_btn_user),
		.o_btn_osd    (o_btn_osd),
		.o_led        (o_led)
	);

endmodule

`default_nettype wire

// File: verification/tb_checker.sv
////////////////////////////////////////////////////////////////////////////
// Testbench checker
//   Reference models of the mixer channel and LED composition
//   Acknowledge handshake monitor and requested output comparisons
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_checker (
	input  logic                       clk,
	input  logic                       resetd,
	input  logic [2:0]                 i_chk_kind,
	input  logic [127:0]               i_chk_name,
	input  hps_audio_pkg::led_cfg_t    i_exp_led_cfg,
	input  logic [4:0]                 i_exp_att,
	input  logic [1:0]                 i_exp_btn,
	input  logic                       i_io_clk,
	input  hps_audio_pkg::stereo_t     i_core_audio,
	input  hps_audio_pkg::stereo_t     i_host_audio,
	input  logic [1:0]                 i_mix,
	input  logic                       i_is_signed,
	input  hps_audio_pkg::led_status_t i_led_status,
	input  logic                       i_io_ack,
	input  hps_audio_pkg::stereo_t     i_audio,
	input  logic [7:0]                 i_led,
	input  logic                       i_btn_user,
	input  logic                       i_btn_osd,
	output int                         o_errors,
	output int                         o_checks
);

	import hps_audio_pkg::*;

	int   hi_cnt;
	logic ack_p;

	initial begin
		o_errors = 0;
		o_checks = 0;
		hi_cnt   = 0;
		ack_p    = 1'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////////////////////

	// Core plus host with unsigned cores halved
	function automatic int sum_ref(input sample_t core, input sample_t host, input logic sgn);
		int s;
		if (sgn) begin
			s = core;
		end else begin
			s = core[15:1];
		end
		return s + host;
	endfunction

	function automatic sample_t mix_ref(input sample_t core, input sample_t host,
		input sample_t p_core, input sample_t p_host, input logic [1:0] mode,
		input logic sgn, input logic [4:0] att);
		int s;
		int p;
		int v;
		s = sum_ref(core, host, sgn);
		p = sum_ref(p_core, p_host, sgn) >>> 1;
		case (mode)
			2'd0: v = s;
			2'd1: v = s - (s >>> 3) + (p >>> 2);
			2'd2: v = s - (s >>> 2) + (p >>> 1);
			default: v = (s >>> 1) + p;
		endcase
		v = att[4] ? 0 : (v >>> att[3:0]);
		if (v > 32767) begin
			v = 32767;
		end else if (v < -32768) begin
			v = -32768;
		end
		return 16'(v);
	endfunction

	function automatic logic [7:0] led_ref(input led_cfg_t cfg, input led_status_t st);
		logic [7:0] pat;
		logic [7:0] led;
		pat    = 8'h00;
		pat[4] = st.disk[0];
		pat[2] = st.power[1] ? st.power[0] : 1'b1;
		pat[0] = st.user;
		// Each overtaken bit shows the host state
		for (int i = 0; i < 8; i++) begin
			if (cfg.overtake[i]) begin
				led[i] = cfg.state[i];
			end else begin
				led[i] = pat[i];
			end
		end
		return led;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Comparing
	////////////////////////////////////////////////////////////////////////////

	task automatic compare(input logic [127:0] name, input string what,
		input logic [31:0] exp, input logic [31:0] act);
		o_checks++;
		if (exp !== act) begin
			o_errors++;
			$display("CHECK FAILED %0s %0s: expected %h actual %h", name, what, exp, act);
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (i_chk_kind == 3'd1) begin
			compare(i_chk_name, "ack", 0, i_io_ack);
			compare(i_chk_name, "buttons", 0, {i_btn_osd, i_btn_user});
		end
		if (i_chk_kind == 3'd1 || i_chk_kind == 3'd2) begin
			compare(i_chk_name, "led", led_ref(i_exp_led_cfg, i_led_status), i_led);
		end
		if (i_chk_kind == 3'd1 || i_chk_kind == 3'd3) begin
			compare(i_chk_name, "left", mix_ref(i_core_audio.l, i_host_audio.l,
				i_core_audio.r, i_host_audio.r, i_mix, i_is_signed, i_exp_att), i_audio.l);
			compare(i_chk_name, "right", mix_ref(i_core_audio.r, i_host_audio.r,
				i_core_audio.l, i_host_audio.l, i_mix, i_is_signed, i_exp_att), i_audio.r);
		end
		if (i_chk_kind == 3'd4) begin
			compare(i_chk_name, "buttons", i_exp_btn, {i_btn_osd, i_btn_user});
		end
	end

	// Ack rises two cycles into a raised io clock and falls only once it is low
	always @(negedge clk) begin
		if (!resetd) begin
			if (i_io_ack && !ack_p) begin
				compare("ack_handshake", "rise latency", 2, hi_cnt);
				compare("ack_handshake", "io clock at rise", 1, i_io_clk);
			end
			if (!i_io_ack && ack_p) begin
				compare("ack_handshake", "io clock at fall", 0, i_io_clk);
			end
			if (!i_io_clk) begin
				hi_cnt = 0;
			end else if (!i_io_ack) begin
				hi_cnt++;
			end
		end
		ack_p = i_io_ack;
	end

endmodule

`default_nettype wire

// File: verification/tb_hps_audio.sv
////////////////////////////////////////////////////////////////////////////
// Testbench top
//   Clock, reset and random seed
//   Host port, LED, audio and button stimulus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_hps_audio;

	import hps_audio_pkg::*;

	localparam int DEBOUNCE_TICK = 4;
	localparam int ACK_TIMEOUT   = 50;

	logic            clk;
	logic            resetd;
	logic            io_clk;
	logic            io_sel;
	logic [IO_W-1:0] io_din;
	stereo_t         core_audio;
	stereo_t         host_audio;
	logic [1:0]      mix;
	logic            is_signed;
	logic            btn_user;
	logic            btn_osd;
	led_status_t     led_status;
	logic            io_ack;
	stereo_t         audio;
	logic [7:0]      led;
	logic            out_btn_user;
	logic            out_btn_osd;
	led_cfg_t        exp_led_cfg;
	logic [4:0]      exp_att;
	logic [1:0]      exp_btn;
	logic [2:0]      chk_kind;
	logic [127:0]    chk_name;
	int              errors;
	int              checks;
	int              seed;

	always #10 clk = ~clk;

	hps_audio_top #(
		.DEBOUNCE_TICK (DEBOUNCE_TICK)
	) uut (
		.clk          (clk),
		.resetd       (resetd),
		.i_io_clk     (io_clk),
		.i_io_sel     (io_sel),
		.i_io_din     (io_din),
		.i_core_audio (core_audio),
		.i_host_audio (host_audio),
		.i_mix        (mix),
		.i_is_signed  (is_signed),
		.i_btn_user   (btn_user),
		.i_btn_osd    (btn_osd),
		.i_led_status (led_status),
		.o_io_ack     (io_ack),
		.o_audio      (audio),
		.o_led        (led),
		.o_btn_user   (out_btn_user),
		.o_btn_osd    (out_btn_osd)
	);

	tb_checker u_checker (
		.clk           (clk),
		.resetd        (resetd),
		.i_chk_kind    (chk_kind),
		.i_chk_name    (chk_name),
		.i_exp_led_cfg (exp_led_cfg),
		.i_exp_att     (exp_att),
		.i_exp_btn     (exp_btn),
		.i_io_clk      (io_clk),
		.i_core_audio  (core_audio),
		.i_host_audio  (host_audio),
		.i_mix         (mix),
		.i_is_signed   (is_signed),
		.i_led_status  (led_status),
		.i_io_ack      (io_ack),
		.i_audio       (audio),
		.i_led         (led),
		.i_btn_user    (out_btn_user),
		.i_btn_osd     (out_btn_osd),
		.o_errors      (errors),
		.o_checks      (checks)
	);

	////////////////////////////////////////////////////////////////////////////
	// Tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string what);
		$display("%0s", what);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Simulation failed");
		$finish;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge clk);
	endtask

	// One-cycle request to the checker
	task automatic request_check(input logic [2:0] kind, input logic [127:0] name);
		@(posedge clk);
		chk_kind <= kind;
		chk_name <= name;
		@(posedge clk);
		chk_kind <= 3'd0;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		@(negedge clk);
		while (io_ack !== level) begin
			if (n == ACK_TIMEOUT) begin
				abort_run("Timeout: host port acknowledge did not follow the io clock");
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic host_write(input logic [IO_W-1:0] word);
		@(posedge clk);
		io_din <= word;
		io_clk <= 1'b1;
		wait_ack(1'b1);
		@(posedge clk);
		io_clk <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic send_cmd(input logic [CMD_W-1:0] cmd, input logic [IO_W-1:0] data);
		@(posedge clk);
		io_sel <= 1'b1;
		host_write({8'h00, cmd});
		host_write(data);
		@(posedge clk);
		io_sel <= 1'b0;
	endtask

	// Top nibble forced to full scale half the time
	function automatic sample_t near_full();
		logic [31:0] r;
		r = $urandom;
		if (r[20]) begin
			r[15:12] = r[15] ? 4'h8 : 4'h7;
		end
		return r[15:0];
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [IO_W-1:0] word;
		logic [4:0]      att;
		int              rnd;
		seed        = 32'hcbff;
		rnd         = $urandom(seed);
		clk         = 1'b0;
		resetd      = 1'b1;
		io_clk      = 1'b0;
		io_sel      = 1'b0;
		io_din      = '0;
		core_audio  = '0;
		host_audio  = '0;
		mix         = 2'd0;
		is_signed   = 1'b1;
		btn_user    = 1'b0;
		btn_osd     = 1'b0;
		// Power LED handed to the core and off
		led_status  = 5'b0_10_00;
		exp_led_cfg = '0;
		exp_att     = '0;
		exp_btn     = 2'b00;
		chk_kind    = 3'd0;
		chk_name    = '0;
		idle(3);
		resetd <= 1'b0;
		idle(2);
		request_check(3'd1, "reset");

		// LED override, then words outside a command
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			led_status <= 5'($urandom);
			word = 16'($urandom);
			send_cmd(CMD_LED, word);
			exp_led_cfg <= word;
			request_check(3'd2, "led_cmd");
		end
		host_write(16'($urandom));
		request_check(3'd2, "led_no_cmd");
		send_cmd(8'h30, 16'($urandom));
		request_check(3'd2, "led_other_cmd");

		// Every crossfeed mode and signedness, full scale then shifted and muted
		for (int m = 0; m < 4; m++) begin
			for (int s = 0; s < 2; s++) begin
				for (int k = 0; k < 3; k++) begin
					@(posedge clk);
					core_audio <= '{l: near_full(), r: near_full()};
					host_audio <= '{l: near_full(), r: near_full()};
					mix        <= 2'(m);
					is_signed  <= 1'(s);
					att = (k == 0) ? 5'd0 : {k == 2, 4'($urandom % 5)};
					send_cmd(CMD_VOL, {11'd0, att});
					exp_att <= att;
					idle(12);
					request_check(3'd3, "audio_mix");
				end
			end
		end

		// Debounce set and single-tick glitch, then one button cleared at a time
		@(posedge clk);
		btn_user <= 1'b1;
		btn_osd  <= 1'b1;
		exp_btn  <= 2'b11;
		idle(10 * DEBOUNCE_TICK);
		request_check(3'd4, "btn_set");
		@(posedge clk);
		btn_user <= 1'b0;
		btn_osd  <= 1'b0;
		idle(DEBOUNCE_TICK - 1);
		@(posedge clk);
		btn_user <= 1'b1;
		btn_osd  <= 1'b1;
		request_check(3'd4, "btn_glitch");
		idle(10 * DEBOUNCE_TICK);
		request_check(3'd4, "btn_hold");
		@(posedge clk);
		btn_user <= 1'b0;
		exp_btn  <= 2'b10;
		idle(10 * DEBOUNCE_TICK);
		request_check(3'd4, "btn_clear_user");
		@(posedge clk);
		btn_osd <= 1'b0;
		exp_btn <= 2'b00;
		idle(10 * DEBOUNCE_TICK);
		request_check(3'd4, "btn_clear");

		idle(2);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
hw/hps_audio_pkg.sv
hw/hps_cmd_decoder.sv
hw/audio_mix_channel.sv
hw/board_io.sv
hw/hps_audio_top.sv
verification/tb_checker.sv
verification/tb_hps_audio.sv
